// ==== project.f ====
+incdir+rtl
rtl/scope_pkg.sv
rtl/scope_regs.sv
rtl/scope_dec_avg.sv
rtl/scope_edge.sv
rtl/scope_acq.sv
rtl/scope_top.sv
test/scope_clkgen.sv
test/scope_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the scope testbench with verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f --top-module scope_tb -o scope_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out="$(./obj_dir/scope_sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TB PASSED$"; then
  exit 0
fi
echo "pass message not found"
exit 1

// ==== test/scope_tb.sv ====
`timescale 1ns/10ps
`include "scope_settings.svh"

module scope_tb;

  localparam int K_WR = 0, K_RD = 1, K_RAMP = 2, K_TRI = 3, K_EXT = 4, K_EXP = 5;

  typedef struct {
    int kind;
    int addr;
    int data;  // write value, read expect, ext bits, expected outputs
    int n;     // burst length, expected trg_out pulses
    int p;     // ramp start or amplitude
    int q;     // ramp step or period
  } entry_t;

  logic bus, rst;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [`SCOPE_AW-1:0] awaddr, araddr;
  logic [31:0] wdata, rdata;
  logic [3:0] wstrb;
  logic [1:0] bresp, rresp;
  logic sti_valid, sti_ready, sto_valid, sto_ready;
  scope_pkg::sample_t sti_data, sto_data;
  logic [`SCOPE_TWA-1:0] trg_ext;
  logic trg_swo, trg_out;

  entry_t tbl[$];
  int     exp_q[$];               // expected output samples
  int     seed = 98;
  int     out_cnt, trg_cnt, swo_cnt;
  // reference model state
  int     m_sel, m_dly, m_lvl, m_hst, m_edg, m_avg, m_dec, m_shr;
  int     m_wcnt, m_cnt, m_trgn, m_swon;
  longint m_wsum;
  bit     m_acq, m_trg, m_armed;

  scope_clkgen clk_i (.bus, .rst);

  scope_top dut_i (.*);

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  task automatic stop_run(string msg);
    $display("%s at %0t", msg, $time);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string name, int expv, int actv);
    assert (expv == actv) else begin
      $display("Mismatch at %0t: %s expected %0d (0x%0h), got %0d (0x%0h)",
               $time, name, expv, expv, actv, actv);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic void take_trigger();
    if (m_acq && !m_trg) begin
      m_trg = 1;
      if (m_cnt == 0) m_acq = 0;  // zero delay stops right away
    end
  endfunction

  function automatic void model_ctl(int d);
    if (d[1]) m_swon++;  // trg_swo pulses regardless
    if (d[0]) begin
      m_wcnt  = 0;
      m_wsum  = 0;
      m_acq   = 0;
      m_trg   = 0;
      m_cnt   = 0;
      m_armed = 0;
    end else if (d[2]) begin
      m_acq = 1;
      m_trg = 0;
      m_cnt = m_dly;
    end else if (d[1] && m_sel == 0) begin
      take_trigger();
    end
  endfunction

  // one decimated sample through acq gate and edge detector
  function automatic void model_stage(int d);
    bit fire;
    fire = 0;
    if (m_acq) begin
      exp_q.push_back(d);
      if (m_trg) begin
        m_cnt--;
        if (m_cnt == 0) m_acq = 0;
      end
    end
    if (!m_edg) begin
      if (m_armed && d >= m_lvl) fire = 1;
      else if (d < m_lvl - m_hst) m_armed = 1;
    end else begin
      if (m_armed && d <= m_lvl) fire = 1;
      else if (d > m_lvl + m_hst) m_armed = 1;
    end
    if (fire) begin
      m_armed = 0;
      m_trgn++;
      if (m_sel == 1) take_trigger();
    end
  endfunction

  function automatic void model_sample(int s);
    longint v;
    logic signed [`SCOPE_DWI-1:0] t;
    m_wsum += s;
    if (m_dec <= 1 || m_wcnt >= m_dec - 1) begin  // window closes
      v = m_wsum >>> m_shr;
      t = v[`SCOPE_DWI-1:0];
      m_wcnt = 0;
      m_wsum = 0;
      model_stage(m_avg ? int'(t) : s);
    end else begin
      m_wcnt++;
    end
  endfunction

  function automatic void model_write(int a, int d);
    case (a)
      `SCOPE_REG_CTL: model_ctl(d);
      `SCOPE_REG_SEL: m_sel = d & 7;
      `SCOPE_REG_DLY: m_dly = d;
      `SCOPE_REG_LVL: m_lvl = ((d & 'h3fff) ^ 'h2000) - 'h2000;  // sign extend 14 bits
      `SCOPE_REG_HST: m_hst = d & 'h3fff;
      `SCOPE_REG_EDG: m_edg = d & 1;
      `SCOPE_REG_AVG: m_avg = d & 1;
      `SCOPE_REG_DEC: m_dec = d & 'h1ffff;
      `SCOPE_REG_SHR: m_shr = d & 'hf;
      default: ;
    endcase
  endfunction

  function automatic int tri_wave(int i, int amp, int per);
    int ph, half;
    ph   = i % per;
    half = per / 2;
    if (ph < half) return -amp + 2 * amp * ph / half;
    return amp - 2 * amp * (ph - half) / half;
  endfunction

  ////////////////////////////////////////////////////////////
  // bus and stream drivers
  ////////////////////////////////////////////////////////////

  task automatic axi_write(int a, int d);
    @(negedge bus);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = a[`SCOPE_AW-1:0];
    wdata   = d;
    #3;
    while (!awready) begin
      @(negedge bus);
      #3;
    end
    check_value("wready", 1, int'(wready));  // both readies in the accept cycle
    @(negedge bus);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    #3;
    while (!bvalid) begin
      @(negedge bus);
      #3;
    end
    check_value("bresp", 0, int'(bresp));  // okay
  endtask

  task automatic axi_read(int a, output int d);
    @(negedge bus);
    arvalid = 1'b1;
    araddr  = a[`SCOPE_AW-1:0];
    #3;
    while (!arready) begin
      @(negedge bus);
      #3;
    end
    @(negedge bus);
    arvalid = 1'b0;
    #3;
    while (!rvalid) begin
      @(negedge bus);
      #3;
    end
    check_value("rresp", 0, int'(rresp));  // okay
    d = rdata;
  endtask

  task automatic drive_sample(int v);
    @(negedge bus);
    sti_valid = 1'b1;
    sti_data  = v[`SCOPE_DWI-1:0];
    #3;
    while (!sti_ready) begin  // held until accepted
      @(negedge bus);
      #3;
    end
  endtask

  task automatic run_burst(entry_t e);
    int v;
    for (int i = 0; i < e.n; i++) begin
      v = (e.kind == K_RAMP) ? e.p + e.q * i : tri_wave(i, e.p, e.q);
      model_sample(v);
      drive_sample(v);
    end
    @(negedge bus) sti_valid = 0;
    while (exp_q.size() != 0) @(negedge bus);  // drain under back-pressure
    repeat (4) @(negedge bus);
  endtask

  task automatic add_entry(int k, int a, int d, int n = 0, int p = 0, int q = 0);
    entry_t e;
    e = '{kind: k, addr: a, data: d, n: n, p: p, q: q};
    tbl.push_back(e);
  endtask

  ////////////////////////////////////////////////////////////
  // monitor and random ready
  ////////////////////////////////////////////////////////////

  initial forever begin
    @(negedge bus);
    sto_ready = $random(seed) & 1;
  end

  initial forever begin
    @(negedge bus);
    #3;  // sampled where everything is settled
    if (sto_valid === 1'b1 && sto_ready) begin
      assert (exp_q.size() != 0)
        else stop_run("output sample arrived while none was expected");
      check_value("sto_data", exp_q.pop_front(), int'(sto_data));
      out_cnt++;
    end
    if (trg_out === 1'b1) trg_cnt++;
    if (trg_swo === 1'b1) swo_cnt++;
  end

  ////////////////////////////////////////////////////////////
  // table
  ////////////////////////////////////////////////////////////

  task automatic build_table();
    int offs[10] = '{'h00, 'h08, 'h0c, 'h10, 'h14, 'h18, 'h24, 'h28, 'h2c, 'h40};
    foreach (offs[i]) add_entry(K_RD, offs[i], 0);
    add_entry(K_RD, 'h04, 0);  // unmapped
    add_entry(K_RD, 'h7c, 0);
    // readback masked to field width
    add_entry(K_WR, `SCOPE_REG_SEL, -1);
    add_entry(K_RD, `SCOPE_REG_SEL, 7);
    add_entry(K_WR, `SCOPE_REG_DLY, 'hdeadbeef);
    add_entry(K_RD, `SCOPE_REG_DLY, 'hdeadbeef);
    add_entry(K_WR, `SCOPE_REG_LVL, -1);
    add_entry(K_RD, `SCOPE_REG_LVL, 'h3fff);
    add_entry(K_WR, `SCOPE_REG_HST, -1);
    add_entry(K_RD, `SCOPE_REG_HST, 'h3fff);
    add_entry(K_WR, `SCOPE_REG_EDG, -1);
    add_entry(K_RD, `SCOPE_REG_EDG, 1);
    add_entry(K_WR, `SCOPE_REG_AVG, -1);
    add_entry(K_RD, `SCOPE_REG_AVG, 1);
    add_entry(K_WR, `SCOPE_REG_DEC, -1);
    add_entry(K_RD, `SCOPE_REG_DEC, 'h1ffff);
    add_entry(K_WR, `SCOPE_REG_SHR, -1);
    add_entry(K_RD, `SCOPE_REG_SHR, 'hf);
    add_entry(K_RD, `SCOPE_REG_CNT, 0);
    // plain decimation, free-running acquisition with no trigger
    add_entry(K_WR, `SCOPE_REG_AVG, 0);
    add_entry(K_WR, `SCOPE_REG_DEC, 4);
    add_entry(K_WR, `SCOPE_REG_SEL, 7);
    add_entry(K_WR, `SCOPE_REG_CTL, 4);
    add_entry(K_RAMP, 0, 0, 32, -20, 3);
    add_entry(K_EXP, 0, 8, -1);
    // averaging
    add_entry(K_WR, `SCOPE_REG_AVG, 1);
    add_entry(K_WR, `SCOPE_REG_SHR, 2);
    add_entry(K_RAMP, 0, 0, 16, 1000, -7);
    add_entry(K_EXP, 0, 4, -1);
    // software trigger, delay 5
    add_entry(K_WR, `SCOPE_REG_CTL, 1);
    add_entry(K_WR, `SCOPE_REG_AVG, 0);
    add_entry(K_WR, `SCOPE_REG_SEL, 0);
    add_entry(K_WR, `SCOPE_REG_DLY, 5);
    add_entry(K_WR, `SCOPE_REG_CTL, 4);
    add_entry(K_RD, `SCOPE_REG_CTL, 4);
    add_entry(K_RAMP, 0, 0, 8, 50, 1);
    add_entry(K_WR, `SCOPE_REG_CTL, 2);
    add_entry(K_RD, `SCOPE_REG_CTL, 6);
    add_entry(K_RAMP, 0, 0, 40, 60, 2);
    add_entry(K_RD, `SCOPE_REG_CTL, 2);
    add_entry(K_RD, `SCOPE_REG_CNT, 0);
    add_entry(K_EXP, 0, 7, -1);
    // edge trigger, rising then falling
    add_entry(K_WR, `SCOPE_REG_CTL, 1);
    add_entry(K_WR, `SCOPE_REG_LVL, 100);
    add_entry(K_WR, `SCOPE_REG_HST, 20);
    add_entry(K_WR, `SCOPE_REG_EDG, 0);
    add_entry(K_WR, `SCOPE_REG_SEL, 1);
    add_entry(K_WR, `SCOPE_REG_DLY, 3);
    add_entry(K_WR, `SCOPE_REG_CTL, 4);
    add_entry(K_TRI, 0, 0, 256, 300, 64);
    add_entry(K_EXP, 0, -1, 4);
    add_entry(K_RD, `SCOPE_REG_CTL, 2);
    add_entry(K_WR, `SCOPE_REG_CTL, 1);
    add_entry(K_WR, `SCOPE_REG_EDG, 1);
    add_entry(K_WR, `SCOPE_REG_CTL, 4);
    add_entry(K_TRI, 0, 0, 256, 300, 64);
    add_entry(K_EXP, 0, -1, 4);
    add_entry(K_RD, `SCOPE_REG_CTL, 2);
    // external trigger on bit 1, then clear mid-run
    add_entry(K_WR, `SCOPE_REG_CTL, 1);
    add_entry(K_WR, `SCOPE_REG_SEL, 3);
    add_entry(K_WR, `SCOPE_REG_DLY, 4);
    add_entry(K_WR, `SCOPE_REG_CTL, 4);
    add_entry(K_EXT, 0, 1);
    add_entry(K_RD, `SCOPE_REG_CTL, 4);
    add_entry(K_EXT, 0, 2);
    add_entry(K_RD, `SCOPE_REG_CTL, 6);
    add_entry(K_RAMP, 0, 0, 8, 0, 1);
    add_entry(K_RD, `SCOPE_REG_CNT, 2);
    add_entry(K_WR, `SCOPE_REG_CTL, 1);
    add_entry(K_RD, `SCOPE_REG_CTL, 0);
    add_entry(K_RAMP, 0, 0, 8, 0, 1);
    add_entry(K_EXP, 0, 2, -1);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int     rd;
    longint budget;
    awvalid   = 1'b0;
    wvalid    = 1'b0;
    arvalid   = 1'b0;
    awaddr    = '0;
    araddr    = '0;
    wdata     = '0;
    wstrb     = 4'hf;
    bready    = 1'b1;
    rready    = 1'b1;
    sti_valid = 1'b0;
    sti_data  = '0;
    sto_ready = 1'b0;
    trg_ext   = '0;
    build_table();
    budget = 5;
    foreach (tbl[i]) budget += 20 * ((tbl[i].kind == K_RAMP || tbl[i].kind == K_TRI) ?
                                     tbl[i].n : 1);
    fork
      begin
        #(budget * 8);
        stop_run("watchdog expired, the DUT stopped responding");
      end
    join_none
    @(negedge rst);
    foreach (tbl[i]) begin
      case (tbl[i].kind)
        K_WR: begin
          model_write(tbl[i].addr, tbl[i].data);
          axi_write(tbl[i].addr, tbl[i].data);
        end
        K_RD: begin
          axi_read(tbl[i].addr, rd);
          check_value($sformatf("rdata[0x%0h]", tbl[i].addr), tbl[i].data, rd);
        end
        K_RAMP, K_TRI: run_burst(tbl[i]);
        K_EXT: begin
          @(negedge bus) trg_ext = tbl[i].data[`SCOPE_TWA-1:0];
          if (m_sel >= 2 && m_sel <= 5 && tbl[i].data[m_sel-2]) take_trigger();
          repeat (3) @(negedge bus);
          trg_ext = '0;
          repeat (2) @(negedge bus);
        end
        default: begin  // count checkpoint
          check_value("trg_out count", m_trgn, trg_cnt);
          check_value("trg_swo count", m_swon, swo_cnt);
          if (tbl[i].data >= 0) check_value("sto count", tbl[i].data, out_cnt);
          if (tbl[i].n >= 0) check_value("trg_out count", tbl[i].n, trg_cnt);
          out_cnt = 0;
          trg_cnt = 0;
          swo_cnt = 0;
          m_trgn  = 0;
          m_swon  = 0;
        end
      endcase
    end
    if (exp_q.size() == 0) begin
      $display("TB PASSED");
    end else begin
      $display("expected output samples never arrived");
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== test/scope_clkgen.sv ====
`timescale 1ns/10ps

module scope_clkgen (
  output logic bus,
  output logic rst
);

  initial begin
    bus = 1'b0;
    forever #4 bus = ~bus;  // 8 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (5) @(posedge bus);
    @(negedge bus) rst = 1'b0;  // released on a falling edge
  end

endmodule

// ==== rtl/scope_top.sv ====
`timescale 1ns/10ps
`include "scope_settings.svh"

module scope_top (
  input  logic                  bus,
  input  logic                  rst,
  // axi4-lite slave
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [`SCOPE_AW-1:0]  awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [31:0]           wdata,
  input  logic [3:0]            wstrb,
  output logic                  bvalid,
  input  logic                  bready,
  output logic [1:0]            bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [`SCOPE_AW-1:0]  araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [31:0]           rdata,
  output logic [1:0]            rresp,
  // sample streams
  input  logic                  sti_valid,
  output logic                  sti_ready,
  input  scope_pkg::sample_t    sti_data,
  output logic                  sto_valid,
  input  logic                  sto_ready,
  output scope_pkg::sample_t    sto_data,
  // triggers
  input  logic [`SCOPE_TWA-1:0] trg_ext,
  output logic                  trg_swo,
  output logic                  trg_out
);

  // configuration
  logic [2:0]            cfg_sel;
  logic [31:0]           cfg_dly;
  scope_pkg::sample_t    cfg_lvl;
  logic [`SCOPE_DWI-1:0] cfg_hst;
  logic                  cfg_edg;
  logic                  cfg_avg;
  logic [`SCOPE_DWC-1:0] cfg_dec;
  logic [`SCOPE_DWS-1:0] cfg_shr;
  // control and status
  logic                  ctl_rst, ctl_trg, ctl_acq;
  logic                  sts_trg, sts_acq;
  logic [31:0]           sts_dly;
  // decimated stream
  logic                  dec_valid, dec_ready;
  scope_pkg::sample_t    dec_data;

  assign trg_swo = ctl_trg;

  scope_regs regs_i (
    .bus, .rst,
    .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
    .cfg_sel, .cfg_dly, .cfg_lvl, .cfg_hst, .cfg_edg, .cfg_avg, .cfg_dec, .cfg_shr,
    .ctl_rst, .ctl_trg, .ctl_acq,
    .sts_trg, .sts_acq, .sts_dly
  );

  scope_dec_avg dec_i (
    .bus, .rst, .ctl_rst, .cfg_avg, .cfg_dec, .cfg_shr,
    .sti_valid, .sti_ready, .sti_data,
    .sto_valid (dec_valid), .sto_ready (dec_ready), .sto_data (dec_data)
  );

  scope_edge edge_i (
    .bus, .rst, .ctl_rst, .cfg_edg, .cfg_lvl, .cfg_hst,
    .str_valid (dec_valid), .str_ready (dec_ready), .str_data (dec_data),
    .trg_out
  );

  scope_acq acq_i (
    .bus, .rst, .ctl_rst, .ctl_acq, .ctl_trg,
    .trg_edge (trg_out), .trg_ext, .cfg_sel, .cfg_dly,
    .sti_valid (dec_valid), .sti_ready (dec_ready), .sti_data (dec_data),
    .sto_valid, .sto_ready, .sto_data,
    .sts_acq, .sts_trg, .sts_dly
  );

endmodule

// ==== rtl/scope_acq.sv ====
`timescale 1ns/10ps
`include "scope_settings.svh"

module scope_acq (
  input  logic                  bus,
  input  logic                  rst,
  input  logic                  ctl_rst,
  input  logic                  ctl_acq,   // start a run
  input  logic                  ctl_trg,   // software trigger
  // trigger sources
  input  logic                  trg_edge,
  input  logic [`SCOPE_TWA-1:0] trg_ext,
  // configuration
  input  logic [2:0]            cfg_sel,
  input  logic [31:0]           cfg_dly,
  // decimated stream in
  input  logic                  sti_valid,
  output logic                  sti_ready,
  input  scope_pkg::sample_t    sti_data,
  // gated stream out
  output logic                  sto_valid,
  input  logic                  sto_ready,
  output scope_pkg::sample_t    sto_data,
  // status
  output logic                  sts_acq,
  output logic                  sts_trg,
  output logic [31:0]           sts_dly
);

  logic trg_mux;  // selected trigger
  logic sto_trn;  // output transfer

  ////////////////////////////////////////////////////////////
  // trigger select
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (cfg_sel)
      3'd0:    trg_mux = ctl_trg;
      3'd1:    trg_mux = trg_edge;
      3'd2:    trg_mux = trg_ext[0];
      3'd3:    trg_mux = trg_ext[1];
      3'd4:    trg_mux = trg_ext[2];
      3'd5:    trg_mux = trg_ext[3];
      default: trg_mux = 1'b0;  // no trigger
    endcase
  end

  ////////////////////////////////////////////////////////////
  // stream gating
  ////////////////////////////////////////////////////////////

  // idle: samples are accepted and dropped
  assign sto_valid = sti_valid & sts_acq;
  assign sti_ready = sts_acq ? sto_ready : 1'b1;
  assign sto_data  = sti_data;
  assign sto_trn   = sto_valid & sto_ready;

  ////////////////////////////////////////////////////////////
  // arm / trigger / delay
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst || ctl_rst) begin
      sts_acq <= 1'b0;
      sts_trg <= 1'b0;
      sts_dly <= '0;
    end else if (ctl_acq) begin
      sts_acq <= 1'b1;
      sts_trg <= 1'b0;
      sts_dly <= cfg_dly;
    end else if (sts_acq) begin
      if (!sts_trg) begin
        if (trg_mux) begin
          sts_trg <= 1'b1;
          if (sts_dly == 0) sts_acq <= 1'b0;  // zero delay ends on trigger
        end
      end else if (sto_trn) begin
        // post-trigger samples, last one ends the run
        sts_dly <= sts_dly - 1'b1;
        if (sts_dly == 1) sts_acq <= 1'b0;
      end
    end
  end

endmodule

// ==== rtl/scope_edge.sv ====
`timescale 1ns/10ps
`include "scope_settings.svh"

module scope_edge (
  input  logic                  bus,
  input  logic                  rst,
  input  logic                  ctl_rst,
  // configuration
  input  logic                  cfg_edg,  // 0 rising, 1 falling
  input  scope_pkg::sample_t    cfg_lvl,
  input  logic [`SCOPE_DWI-1:0] cfg_hst,
  // monitored stream, nothing driven back
  input  logic                  str_valid,
  input  logic                  str_ready,
  input  scope_pkg::sample_t    str_data,
  // trigger pulse
  output logic                  trg_out
);

  localparam int XW = `SCOPE_DWI + 2;  // room for level +/- hysteresis

  logic                 trn;     // sample transfer seen
  logic signed [XW-1:0] smp;     // sample, extended
  logic signed [XW-1:0] lvl;     // level, extended
  logic signed [XW-1:0] thr_lo;  // rising arm threshold
  logic signed [XW-1:0] thr_hi;  // falling arm threshold
  logic                 arm;     // sample past the arm threshold
  logic                 hit;     // sample reached the level
  logic                 armed;

  assign trn    = str_valid & str_ready;
  assign smp    = str_data;
  assign lvl    = cfg_lvl;
  assign thr_lo = lvl - $signed({2'b00, cfg_hst});
  assign thr_hi = lvl + $signed({2'b00, cfg_hst});

  // falling mode mirrors rising
  assign arm = cfg_edg ? (smp > thr_hi) : (smp < thr_lo);
  assign hit = cfg_edg ? (smp <= lvl)   : (smp >= lvl);

  always_ff @(posedge bus) begin
    if (rst || ctl_rst) begin
      armed   <= 1'b0;
      trg_out <= 1'b0;
    end else begin
      trg_out <= 1'b0;
      if (trn) begin
        if (armed && hit) begin
          trg_out <= 1'b1;  // fire once
          armed   <= 1'b0;
        end else if (arm) begin
          armed <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== rtl/scope_dec_avg.sv ====
`timescale 1ns/10ps
`include "scope_settings.svh"

module scope_dec_avg (
  input  logic                  bus,
  input  logic                  rst,
  input  logic                  ctl_rst,
  // configuration
  input  logic                  cfg_avg,  // output window sum instead of last sample
  input  logic [`SCOPE_DWC-1:0] cfg_dec,  // window length, 0 and 1 pass all
  input  logic [`SCOPE_DWS-1:0] cfg_shr,  // sum scaling
  // input stream
  input  logic                  sti_valid,
  output logic                  sti_ready,
  input  scope_pkg::sample_t    sti_data,
  // output stream
  output logic                  sto_valid,
  input  logic                  sto_ready,
  output scope_pkg::sample_t    sto_data
);

  localparam int SW = `SCOPE_DWI + `SCOPE_DWC;  // full precision sum

  logic                  sti_trn;  // input transfer
  logic                  win_end;  // this transfer closes the window
  logic [`SCOPE_DWC-1:0] cnt;      // samples taken so far in window
  logic signed [SW-1:0]  sum;      // running sum, without current sample
  logic signed [SW-1:0]  sum_add;  // running sum with current sample
  logic signed [SW-1:0]  sum_shr;  // scaled window sum

  // single output register, input waits while it is stuck
  assign sti_ready = ~sto_valid | sto_ready;
  assign sti_trn   = sti_valid & sti_ready;

  assign win_end = (cfg_dec <= 1) || (cnt >= cfg_dec - 1'b1);  // >= covers a shrunk factor
  assign sum_add = sum + sti_data;
  assign sum_shr = sum_add >>> cfg_shr;  // arithmetic, sum is signed

  ////////////////////////////////////////////////////////////
  // window count and sum
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst || ctl_rst) begin
      cnt <= '0;
      sum <= '0;
    end else if (sti_trn) begin
      if (win_end) begin
        cnt <= '0;
        sum <= '0;  // next window starts empty
      end else begin
        cnt <= cnt + 1'b1;
        sum <= sum_add;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst || ctl_rst) begin
      sto_valid <= 1'b0;
    end else if (sti_trn && win_end) begin
      sto_valid <= 1'b1;
    end else if (sto_ready) begin
      sto_valid <= 1'b0;  // drained
    end
  end

  always_ff @(posedge bus) begin
    if (sti_trn && win_end) begin
      sto_data <= cfg_avg ? sum_shr[`SCOPE_DWI-1:0] : sti_data;  // truncate to sample
    end
  end

endmodule

// ==== rtl/scope_regs.sv ====
`timescale 1ns/10ps
`include "scope_settings.svh"

module scope_regs (
  input  logic                      bus,
  input  logic                      rst,
  // axi4-lite write address
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [`SCOPE_AW-1:0]      awaddr,
  // write data
  input  logic                      wvalid,
  output logic                      wready,
  input  logic [31:0]               wdata,
  input  logic [3:0]                wstrb,   // whole word always written
  // write response
  output logic                      bvalid,
  input  logic                      bready,
  output logic [1:0]                bresp,
  // read address
  input  logic                      arvalid,
  output logic                      arready,
  input  logic [`SCOPE_AW-1:0]      araddr,
  // read data
  output logic                      rvalid,
  input  logic                      rready,
  output logic [31:0]               rdata,
  output logic [1:0]                rresp,
  // configuration
  output logic [2:0]                cfg_sel,
  output logic [31:0]               cfg_dly,
  output scope_pkg::sample_t        cfg_lvl,
  output logic [`SCOPE_DWI-1:0]     cfg_hst,
  output logic                      cfg_edg,
  output logic                      cfg_avg,
  output logic [`SCOPE_DWC-1:0]     cfg_dec,
  output logic [`SCOPE_DWS-1:0]     cfg_shr,
  // control pulses
  output logic                      ctl_rst,
  output logic                      ctl_trg,
  output logic                      ctl_acq,
  // status from acquisition
  input  logic                      sts_trg,
  input  logic                      sts_acq,
  input  logic [31:0]               sts_dly
);

  logic                 wr_acc;   // write accepted this cycle
  logic                 rd_acc;   // read accepted this cycle
  logic                 wr_ctl;   // write hits control word
  scope_pkg::ctl_word_u wr_word;  // wdata seen as commands
  scope_pkg::ctl_word_u sts_word; // status as read back

  ////////////////////////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////////////////////////

  assign wr_acc  = awvalid & wvalid & ~bvalid;
  assign awready = wr_acc;
  assign wready  = wr_acc;
  assign rd_acc  = arvalid & ~rvalid;
  assign arready = rd_acc;

  assign bresp = 2'b00;  // always okay
  assign rresp = 2'b00;

  always_ff @(posedge bus) begin
    if (rst) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_acc)      bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (rd_acc)      rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // configuration and control pulses
  ////////////////////////////////////////////////////////////

  assign wr_word = wdata;
  assign wr_ctl  = wr_acc && (awaddr == `SCOPE_REG_CTL);

  always_ff @(posedge bus) begin
    if (rst) begin
      cfg_sel <= '0;
      cfg_dly <= '0;
      cfg_lvl <= '0;
      cfg_hst <= '0;
      cfg_edg <= 1'b0;
      cfg_avg <= 1'b0;
      cfg_dec <= '0;
      cfg_shr <= '0;
      ctl_rst <= 1'b0;
      ctl_trg <= 1'b0;
      ctl_acq <= 1'b0;
    end else begin
      // one-cycle pulses, the cycle after accept
      ctl_rst <= wr_ctl & wr_word.cmd.clr;
      ctl_trg <= wr_ctl & wr_word.cmd.trg;
      ctl_acq <= wr_ctl & wr_word.cmd.acq;
      if (wr_acc) begin
        case (awaddr)
          `SCOPE_REG_SEL: cfg_sel <= wdata[2:0];
          `SCOPE_REG_DLY: cfg_dly <= wdata;
          `SCOPE_REG_LVL: cfg_lvl <= wdata[`SCOPE_DWI-1:0];
          `SCOPE_REG_HST: cfg_hst <= wdata[`SCOPE_DWI-1:0];
          `SCOPE_REG_EDG: cfg_edg <= wdata[0];
          `SCOPE_REG_AVG: cfg_avg <= wdata[0];
          `SCOPE_REG_DEC: cfg_dec <= wdata[`SCOPE_DWC-1:0];
          `SCOPE_REG_SHR: cfg_shr <= wdata[`SCOPE_DWS-1:0];
          default: ;  // ctl handled above, rest unmapped
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read back
  ////////////////////////////////////////////////////////////

  always_comb begin
    sts_word         = '0;
    sts_word.sts.trg = sts_trg;
    sts_word.sts.acq = sts_acq;
  end

  always_ff @(posedge bus) begin
    if (rd_acc) begin
      case (araddr)
        `SCOPE_REG_CTL: rdata <= sts_word;
        `SCOPE_REG_SEL: rdata <= {29'd0, cfg_sel};
        `SCOPE_REG_DLY: rdata <= cfg_dly;
        `SCOPE_REG_LVL: rdata <= {{(32-`SCOPE_DWI){1'b0}}, cfg_lvl};  // masked, not extended
        `SCOPE_REG_HST: rdata <= {{(32-`SCOPE_DWI){1'b0}}, cfg_hst};
        `SCOPE_REG_EDG: rdata <= {31'd0, cfg_edg};
        `SCOPE_REG_AVG: rdata <= {31'd0, cfg_avg};
        `SCOPE_REG_DEC: rdata <= {{(32-`SCOPE_DWC){1'b0}}, cfg_dec};
        `SCOPE_REG_SHR: rdata <= {{(32-`SCOPE_DWS){1'b0}}, cfg_shr};
        `SCOPE_REG_CNT: rdata <= sts_dly;
        default:        rdata <= 32'd0;
      endcase
    end
  end

endmodule

// ==== rtl/scope_pkg.sv ====
`include "scope_settings.svh"

package scope_pkg;

  // one adc sample, two's complement
  typedef logic signed [`SCOPE_DWI-1:0] sample_t;

  // command bits, as written to offset 0x00
  typedef struct packed {
    logic [28:0] pad;
    logic        acq;  // arm a new acquisition
    logic        trg;  // software trigger
    logic        clr;  // synchronous clear
  } ctl_cmd_t;

  // status bits, as read from offset 0x00
  typedef struct packed {
    logic [28:0] pad;
    logic        acq;  // acquisition running
    logic        trg;  // trigger seen
    logic        rsv;  // always zero
  } ctl_sts_t;

  // same word, decoded per direction
  typedef union packed {
    ctl_cmd_t cmd;
    ctl_sts_t sts;
  } ctl_word_u;

endpackage

// ==== rtl/scope_settings.svh ====
`ifndef SCOPE_SETTINGS_SVH
`define SCOPE_SETTINGS_SVH

// datapath widths
`define SCOPE_DWI 14  // sample
`define SCOPE_DWC 17  // decimation factor
`define SCOPE_DWS 4   // shift amount
`define SCOPE_TWA 4   // external trigger inputs
`define SCOPE_AW  7   // axi address

// register map, byte offsets
`define SCOPE_REG_CTL 7'h00  // write control, read status
`define SCOPE_REG_SEL 7'h08  // trigger select
`define SCOPE_REG_DLY 7'h0c  // post-trigger delay
`define SCOPE_REG_LVL 7'h10  // trigger level, signed
`define SCOPE_REG_HST 7'h14  // hysteresis
`define SCOPE_REG_EDG 7'h18  // 0 rising, 1 falling
`define SCOPE_REG_AVG 7'h24  // averaging enable
`define SCOPE_REG_DEC 7'h28  // decimation factor
`define SCOPE_REG_SHR 7'h2c  // shift right
`define SCOPE_REG_CNT 7'h40  // remaining delay, read only

`endif
